//--- ex_alu.sv
// Single-cycle ALU; shift results are only meaningful while the shared unit grants the ALU port
`timescale 1ns/10ps
module ex_alu
  import ex_op_pkg::*;
(
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  shift_port_if.requester shift_port,
  output word_t   result_o,
  output logic    cmp_result_o
);

  logic  is_shift;
  logic  equal;
  logic  lt_signed;
  logic  lt_unsigned;
  word_t shift_result;

  ////////////////////
  // Shift request
  ////////////////////

  assign is_shift = (operator_i == ALU_SLL) || (operator_i == ALU_SRL) ||
                    (operator_i == ALU_SRA);

  assign shift_port.req         = is_shift;
  assign shift_port.left        = (operator_i == ALU_SLL);
  assign shift_port.arith       = (operator_i == ALU_SRA);
  assign shift_port.operand     = operand_a_i;
  // RV32 uses only the low five bits of rs2
  assign shift_port.amount      = {1'b0, operand_b_i[4:0]};
  assign shift_port.clz_operand = '0;

  assign shift_result = shift_port.gnt ? shift_port.result : '0;

  // Comparators shared by slt and the branch compares
  assign equal       = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  ////////////////////
  // Branch condition
  ////////////////////

  always_comb begin
    case (operator_i)
      ALU_EQ:  cmp_result_o = equal;
      ALU_NE:  cmp_result_o = !equal;
      ALU_LT:  cmp_result_o = lt_signed;
      ALU_GE:  cmp_result_o = !lt_signed;
      ALU_LTU: cmp_result_o = lt_unsigned;
      ALU_GEU: cmp_result_o = !lt_unsigned;
      default: cmp_result_o = 1'b0;
    endcase
  end

  // Result mux
  always_comb begin
    case (operator_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:  result_o = shift_result;
      ALU_SLT:  result_o = word_t'(lt_signed);
      ALU_SLTU: result_o = word_t'(lt_unsigned);
      default:  result_o = word_t'(cmp_result_o);  // branch compares
    endcase
  end

endmodule

//--- ex_ctrl_pkg.sv
// Divider FSM states and the worst-case EX latency that timeouts in the testbench rely on
package ex_ctrl_pkg;

  // Divider FSM
  // IDLE      waits for a gated start
  // NORMALIZE asks the shared unit for CLZ and the aligned divisor
  // ITERATE   runs one restoring step per cycle
  // DONE      holds the result until WB takes it
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_NORMALIZE,
    DIV_ITERATE,
    DIV_DONE
  } div_state_e;

  // Cycles from issue edge to the WB accept edge
  // 1 idle edge, 1 normalize edge, up to 32 steps, 1 accept edge
  localparam int DIV_MAX_CYCLES = 35;

endpackage

//--- ex_div.sv
// Restoring divider with CLZ early start; operands must stay valid until the result is accepted
`timescale 1ns/10ps
module ex_div
  import ex_op_pkg::*;
  import ex_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start_i,
  input  logic    kill_i,
  input  div_op_e operator_i,
  input  word_t   op_a_i,
  input  word_t   op_b_i,
  shift_port_if.requester shift_port,
  input  logic    ready_i,
  output logic    ready_o,
  output logic    valid_o,
  output word_t   result_o
);

  div_state_e state_q;
  div_state_e state_d;

  // Operand magnitudes and sign handling
  logic    is_signed;
  logic    a_neg;
  logic    b_neg;
  word_t   a_mag;
  word_t   b_mag;

  // Working registers
  div_op_e op_q;
  word_t   rem_q;
  word_t   quo_q;
  word_t   dsr_q;     // divisor, left-aligned after normalize
  shamt_t  cnt_q;     // steps left minus one
  logic    quo_neg_q;
  logic    rem_neg_q;
  logic    rem_ge;
  word_t   quo_fix;
  word_t   rem_fix;

  assign is_signed = (operator_i == DIV_DIV) || (operator_i == DIV_REM);
  assign a_neg     = is_signed && op_a_i[WORD_W-1];
  assign b_neg     = is_signed && op_b_i[WORD_W-1];
  assign a_mag     = a_neg ? -op_a_i : op_a_i;
  assign b_mag     = b_neg ? -op_b_i : op_b_i;

  ////////////////////
  // Shared unit use
  ////////////////////

  // CLZ feeds the shift amount in the same cycle
  assign shift_port.req         = (state_q == DIV_NORMALIZE);
  assign shift_port.left        = 1'b1;
  assign shift_port.arith       = 1'b0;
  assign shift_port.operand     = dsr_q;
  assign shift_port.amount      = shift_port.clz_count;
  assign shift_port.clz_operand = dsr_q;

  ////////////////////
  // Control
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      DIV_IDLE:      if (start_i) state_d = DIV_NORMALIZE;
      DIV_NORMALIZE: if (shift_port.gnt) state_d = (dsr_q == '0) ? DIV_DONE : DIV_ITERATE;
      DIV_ITERATE:   if (cnt_q == '0) state_d = DIV_DONE;
      // Leave only when the stage really hands the result to WB, so a halt keeps it
      DIV_DONE:      if (ready_i && start_i) state_d = DIV_IDLE;
      default:       state_d = DIV_IDLE;
    endcase
    if (kill_i) state_d = DIV_IDLE;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Datapath
  assign rem_ge = (rem_q >= dsr_q);

  always_ff @(posedge clk) begin
    case (state_q)
      DIV_IDLE: begin
        op_q      <= operator_i;
        rem_q     <= a_mag;
        dsr_q     <= b_mag;
        quo_q     <= '0;
        quo_neg_q <= a_neg ^ b_neg;
        rem_neg_q <= a_neg;
      end
      DIV_NORMALIZE: begin
        if (dsr_q == '0) begin
          // RISC-V divide by zero, quotient all ones, remainder is the dividend
          quo_q     <= '1;
          quo_neg_q <= 1'b0;
        end else begin
          dsr_q <= shift_port.result;
          cnt_q <= shift_port.clz_count;
        end
      end
      DIV_ITERATE: begin
        if (rem_ge) rem_q <= rem_q - dsr_q;
        quo_q <= {quo_q[WORD_W-2:0], rem_ge};
        dsr_q <= dsr_q >> 1;
        cnt_q <= cnt_q - 1'b1;
      end
      default: ;
    endcase
  end

  // Sign fix; most negative by -1 falls out of the magnitudes
  assign quo_fix  = quo_neg_q ? -quo_q : quo_q;
  assign rem_fix  = rem_neg_q ? -rem_q : rem_q;
  assign result_o = ((op_q == DIV_DIV) || (op_q == DIV_DIVU)) ? quo_fix : rem_fix;

  assign valid_o = (state_q == DIV_DONE);
  assign ready_o = ((state_q == DIV_IDLE) && !start_i) || ((state_q == DIV_DONE) && ready_i);

  // Result must survive WB back-pressure
  a_hold : assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !kill_i |=> valid_o && $stable(result_o));

endmodule

//--- ex_op_pkg.sv
// RV32 only; operator encodings are internal to this stage and are not RISC-V funct fields
package ex_op_pkg;

  // Word and field widths
  localparam int WORD_W    = 32;
  localparam int RF_ADDR_W = 5;
  localparam int SHAMT_W   = 6;   // one bit more than needed so 32 fits
  localparam int ALU_OP_W  = 4;
  localparam int DIV_OP_W  = 2;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [SHAMT_W-1:0]   shamt_t;

  // ALU operators, arithmetic and logic first, then branch compares
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Divider operators
  typedef enum logic [DIV_OP_W-1:0] {
    DIV_DIV,
    DIV_DIVU,
    DIV_REM,
    DIV_REMU
  } div_op_e;

endpackage

//--- ex_stage.sv
// ALU and divider only; upstream must hold all inputs steady until ex_ready_o is high at an edge
`timescale 1ns/10ps
module ex_stage
  import ex_op_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // ID/EX contents
  input  logic     instr_valid_i,
  input  logic     alu_en_i,
  input  logic     div_en_i,
  input  alu_op_e  alu_operator_i,
  input  div_op_e  div_operator_i,
  input  word_t    operand_a_i,
  input  word_t    operand_b_i,
  input  word_t    operand_c_i,
  input  logic     rf_we_i,
  input  rf_addr_t rf_waddr_i,

  // Controller
  input  logic     kill_i,
  input  logic     halt_i,
  input  logic     wb_ready_i,

  output logic     ex_ready_o,
  output logic     ex_valid_o,

  // Forwarding and branch toward IF
  output word_t    rf_wdata_o,
  output logic     branch_decision_o,
  output word_t    branch_target_o,

  // EX/WB register
  output logic     wb_valid_o,
  output logic     wb_rf_we_o,
  output rf_addr_t wb_rf_waddr_o,
  output word_t    wb_rf_wdata_o
);

  logic  instr_valid;
  logic  div_start;
  logic  alu_ready;
  logic  div_ready;
  logic  div_valid;
  word_t alu_result;
  logic  alu_cmp_result;
  word_t div_result;

  shift_port_if div_shift ();
  shift_port_if alu_shift ();

  // Kill and halt both remove the instruction from this cycle
  assign instr_valid = instr_valid_i && !kill_i && !halt_i;
  assign div_start   = div_en_i && instr_valid;

  // Result toward forwarding, invalid cycles are ignored downstream
  assign rf_wdata_o        = div_en_i ? div_result : alu_result;
  assign branch_decision_o = alu_cmp_result;
  assign branch_target_o   = operand_c_i;

  ////////////////////
  // Units
  ////////////////////

  shift_clz_unit shift_clz_unit_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .div_port (div_shift.server),
    .alu_port (alu_shift.server)
  );

  ex_alu ex_alu_inst (
    .operator_i   (alu_operator_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .shift_port   (alu_shift.requester),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_div ex_div_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .kill_i     (kill_i),
    .operator_i (div_operator_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .shift_port (div_shift.requester),
    .ready_i    (wb_ready_i),
    .ready_o    (div_ready),
    .valid_o    (div_valid),
    .result_o   (div_result)
  );

  // ALU is single cycle, so it is ready whenever WB is
  assign alu_ready = wb_ready_i;

  assign ex_ready_o = kill_i || (alu_ready && div_ready && !halt_i);
  assign ex_valid_o = ((alu_en_i) || (div_en_i && div_valid)) && instr_valid;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
      wb_rf_we_o <= 1'b0;
    end else if (ex_valid_o && wb_ready_i) begin
      wb_valid_o <= 1'b1;
      wb_rf_we_o <= rf_we_i;
    end else if (wb_ready_i) begin
      // Nothing to hand over, insert a bubble
      wb_valid_o <= 1'b0;
      wb_rf_we_o <= 1'b0;
    end
  end

  // Write-back payload
  always_ff @(posedge clk) begin
    if (ex_valid_o && wb_ready_i && rf_we_i) begin
      wb_rf_waddr_o <= rf_waddr_i;
      wb_rf_wdata_o <= rf_wdata_o;
    end
  end

  // A kill blocks this cycle and clears a running division by the next one
  a_kill : assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> (!ex_valid_o ##1 !div_valid));

endmodule

//--- project.f
ex_op_pkg.sv
ex_ctrl_pkg.sv
shift_port_if.sv
shift_clz_unit.sv
ex_alu.sv
ex_div.sv
ex_stage.sv
tb_ex_stage.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, exit status follows the test result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f project.f -o tb_ex_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ex_stage_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- shift_clz_unit.sv
// Divider has fixed priority; both ports see the same results so only the granted one may use them
`timescale 1ns/10ps
module shift_clz_unit
  import ex_op_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  shift_port_if.server div_port,
  shift_port_if.server alu_port
);

  logic               sel_div;
  logic               sh_left;
  logic               sh_arith;
  shamt_t             sh_amount;
  word_t              sh_operand;
  word_t              sh_in;
  word_t              sh_out;
  word_t              clz_in;
  shamt_t             clz_cnt;
  logic signed [WORD_W:0] sh_ext;
  logic signed [WORD_W:0] sh_shifted;

  ////////////////////
  // Arbiter
  ////////////////////

  assign sel_div      = div_port.req;
  assign div_port.gnt = div_port.req;
  assign alu_port.gnt = alu_port.req && !div_port.req;

  // Input mux toward the single datapath
  assign sh_left    = sel_div ? div_port.left        : alu_port.left;
  assign sh_arith   = sel_div ? div_port.arith       : alu_port.arith;
  assign sh_amount  = sel_div ? div_port.amount      : alu_port.amount;
  assign sh_operand = sel_div ? div_port.operand     : alu_port.operand;
  assign clz_in     = sel_div ? div_port.clz_operand : alu_port.clz_operand;

  ////////////////////
  // Barrel shifter
  ////////////////////

  // Left shifts reuse the right shifter on bit-reversed data
  always_comb begin
    for (int i = 0; i < WORD_W; i++) begin
      sh_in[i] = sh_left ? sh_operand[WORD_W-1-i] : sh_operand[i];
    end
  end

  // Extra top bit carries the fill value
  assign sh_ext     = {sh_arith & sh_in[WORD_W-1], sh_in};
  assign sh_shifted = sh_ext >>> sh_amount;

  always_comb begin
    for (int i = 0; i < WORD_W; i++) begin
      sh_out[i] = sh_left ? sh_shifted[WORD_W-1-i] : sh_shifted[i];
    end
  end

  // Leading zeros, highest set bit wins, all zero gives WORD_W
  always_comb begin
    clz_cnt = shamt_t'(WORD_W);
    for (int i = 0; i < WORD_W; i++) begin
      if (clz_in[i]) clz_cnt = shamt_t'(WORD_W - 1 - i);
    end
  end

  assign div_port.result    = sh_out;
  assign alu_port.result    = sh_out;
  assign div_port.clz_count = clz_cnt;
  assign alu_port.clz_count = clz_cnt;

  // Never two owners of the shared datapath
  a_one_gnt : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({div_port.gnt, alu_port.gnt}));

endmodule

//--- shift_port_if.sv
// One requester port on the shared shift/CLZ unit; results are combinational and valid only with gnt
`timescale 1ns/10ps
interface shift_port_if import ex_op_pkg::*; ();

  // Request side
  logic   req;
  logic   left;         // 1 shifts left, 0 shifts right
  logic   arith;        // sign fill on right shifts
  word_t  operand;
  shamt_t amount;
  word_t  clz_operand;

  // Response side
  logic   gnt;
  word_t  result;
  shamt_t clz_count;

  modport requester (
    output req, left, arith, operand, amount, clz_operand,
    input  gnt, result, clz_count
  );

  modport server (
    input  req, left, arith, operand, amount, clz_operand,
    output gnt, result, clz_count
  );

endinterface

//--- tb_ex_stage.sv
// One instruction in flight at a time with a bubble after each; halt_i stays low for the whole run
`timescale 1ns/10ps
module tb_ex_stage
  import ex_op_pkg::*;
  import ex_ctrl_pkg::*;
();

  // Write-back entry as the model predicts it
  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    word_t    wdata;
  } wb_entry_t;

  // DUT inputs
  logic     clk;
  logic     rst_n;
  logic     instr_valid_i;
  logic     alu_en_i;
  logic     div_en_i;
  alu_op_e  alu_operator_i;
  div_op_e  div_operator_i;
  word_t    operand_a_i;
  word_t    operand_b_i;
  word_t    operand_c_i;
  logic     rf_we_i;
  rf_addr_t rf_waddr_i;
  logic     kill_i;
  logic     halt_i;
  logic     wb_ready_i;

  // DUT outputs
  logic     ex_ready_o;
  logic     ex_valid_o;
  word_t    rf_wdata_o;
  logic     branch_decision_o;
  word_t    branch_target_o;
  logic     wb_valid_o;
  logic     wb_rf_we_o;
  rf_addr_t wb_rf_waddr_o;
  word_t    wb_rf_wdata_o;

  // Model state
  wb_entry_t exp_q[$];
  int        pending;
  logic      exp_we;
  rf_addr_t  exp_waddr;
  word_t     exp_wdata;
  logic      exp_branch;
  logic      br_active;
  logic      issued;
  logic      wb_valid_d;
  int        errors;
  int        tests_run;
  int        tests_failed;

  ex_stage ex_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    word_t r;
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      // RV32 shifts by rs2[4:0]
      ALU_SLL:  r = a << b[4:0];
      ALU_SRL:  r = a >> b[4:0];
      ALU_SRA:  r = word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(input alu_op_e op, input word_t a, input word_t b);
    logic taken;
    case (op)
      ALU_EQ:  taken = (a == b);
      ALU_NE:  taken = (a != b);
      ALU_LT:  taken = ($signed(a) < $signed(b));
      ALU_GE:  taken = ($signed(a) >= $signed(b));
      ALU_LTU: taken = (a < b);
      ALU_GEU: taken = (a >= b);
      default: taken = 1'b0;
    endcase
    return taken;
  endfunction

  // RISC-V M rules, division truncates toward zero
  function automatic word_t div_model(input div_op_e op, input word_t a, input word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               signed_op;
    word_t              q;
    word_t              r;
    sa        = a;
    sb        = b;
    signed_op = (op == DIV_DIV) || (op == DIV_REM);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (signed_op && (a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
      q = a;
      r = '0;
    end else if (signed_op) begin
      q = sa / sb;
      r = sa % sb;
    end else begin
      q = a / b;
      r = a % b;
    end
    return ((op == DIV_DIV) || (op == DIV_DIVU)) ? q : r;
  endfunction

  // Retire the head entry when a new WB entry shows up
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_d <= 1'b0;
    end else begin
      wb_valid_d <= wb_valid_o;
      if (wb_valid_o && !wb_valid_d && (exp_q.size() > 0)) begin
        void'(exp_q.pop_front());
        pending = exp_q.size();
        if (exp_q.size() > 0) begin
          exp_we    = exp_q[0].we;
          exp_waddr = exp_q[0].waddr;
          exp_wdata = exp_q[0].wdata;
        end
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  a_reset_quiet : assert property (@(posedge clk) disable iff (!rst_n)
    !issued |-> !wb_valid_o && !wb_rf_we_o && !ex_valid_o)
    else begin
      $display("FAIL t=%0t wb_valid_o/wb_rf_we_o/ex_valid_o got %b%b%b expected 000",
               $time, wb_valid_o, wb_rf_we_o, ex_valid_o);
      errors++;
    end

  // Every rise of wb_valid_o must match one outstanding instruction
  a_no_extra : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_valid_o) |-> pending != 0)
    else begin
      $display("ERROR t=%0t wb_valid_o rose with no instruction outstanding", $time);
      errors++;
    end

  a_wb_we : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_valid_o) |-> wb_rf_we_o == exp_we)
    else begin
      $display("FAIL t=%0t wb_rf_we_o got %b expected %b", $time, wb_rf_we_o, exp_we);
      errors++;
    end

  a_wdata : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_valid_o) && exp_we |-> wb_rf_wdata_o == exp_wdata)
    else begin
      $display("FAIL t=%0t wb_rf_wdata_o got %h expected %h", $time, wb_rf_wdata_o, exp_wdata);
      errors++;
    end

  a_waddr : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_valid_o) && exp_we |-> wb_rf_waddr_o == exp_waddr)
    else begin
      $display("FAIL t=%0t wb_rf_waddr_o got %0d expected %0d", $time, wb_rf_waddr_o, exp_waddr);
      errors++;
    end

  // Forwarded result while EX holds a valid register writer
  a_fwd_data : assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && exp_we |-> rf_wdata_o == exp_wdata)
    else begin
      $display("FAIL t=%0t rf_wdata_o got %h expected %h", $time, rf_wdata_o, exp_wdata);
      errors++;
    end

  // Accepted instruction lands in WB at that same edge
  a_wb_follow : assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_i && !kill_i && ex_ready_o |=> $rose(wb_valid_o))
    else begin
      $display("ERROR t=%0t wb_valid_o did not rise after an accepted instruction", $time);
      errors++;
    end

  a_branch : assert property (@(posedge clk) disable iff (!rst_n)
    br_active |-> branch_decision_o == exp_branch)
    else begin
      $display("FAIL t=%0t branch_decision_o got %b expected %b",
               $time, branch_decision_o, exp_branch);
      errors++;
    end

  a_target : assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_i |-> branch_target_o == operand_c_i)
    else begin
      $display("FAIL t=%0t branch_target_o got %h expected %h",
               $time, branch_target_o, operand_c_i);
      errors++;
    end

  a_bp_ready : assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i && !kill_i |-> !ex_ready_o)
    else begin
      $display("FAIL t=%0t ex_ready_o got 1 expected 0 while wb_ready_i low", $time);
      errors++;
    end

  a_bp_hold : assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(wb_valid_o) && $stable(wb_rf_we_o) &&
                    $stable(wb_rf_wdata_o) && $stable(wb_rf_waddr_o))
    else begin
      $display("ERROR t=%0t EX/WB register changed while wb_ready_i was low", $time);
      errors++;
    end

  a_kill_ready : assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> ex_ready_o)
    else begin
      $display("FAIL t=%0t ex_ready_o got 0 expected 1 while kill_i high", $time);
      errors++;
    end

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic drive_idle();
    instr_valid_i = 1'b0;
    alu_en_i      = 1'b0;
    div_en_i      = 1'b0;
    rf_we_i       = 1'b0;
    kill_i        = 1'b0;
    br_active     = 1'b0;
  endtask

  task automatic push_expected(input logic we, input rf_addr_t waddr, input word_t wdata);
    wb_entry_t e;
    e.we    = we;
    e.waddr = waddr;
    e.wdata = wdata;
    exp_q.push_back(e);
    pending = exp_q.size();
    // Head only moves here when nothing else is outstanding
    if (exp_q.size() == 1) begin
      exp_we    = we;
      exp_waddr = waddr;
      exp_wdata = wdata;
    end
  endtask

  // Ready is sampled at the falling edge, where inputs and state are settled
  task automatic wait_accept(input string what);
    int   n;
    logic timed_out;
    n = 0;
    @(negedge clk);
    while (!ex_ready_o && (n < DIV_MAX_CYCLES + 8)) begin
      @(negedge clk);
      n++;
    end
    timed_out = !ex_ready_o;
    if (timed_out) begin
      $display("TIMEOUT t=%0t %s not accepted within %0d cycles", $time, what, n);
      errors++;
      exp_q.delete();
      pending = 0;
    end
    @(posedge clk);
    #2;
    // Flush a stuck instruction so the next test starts clean
    if (timed_out) begin
      kill_i = 1'b1;
      @(posedge clk);
      #2;
      kill_i = 1'b0;
    end
  endtask

  task automatic run_alu(input alu_op_e op, input word_t a, input word_t b);
    logic     is_cmp;
    rf_addr_t waddr;
    is_cmp         = (op >= ALU_EQ);
    waddr          = rf_addr_t'($urandom());
    issued         = 1'b1;
    instr_valid_i  = 1'b1;
    alu_en_i       = 1'b1;
    div_en_i       = 1'b0;
    alu_operator_i = op;
    operand_a_i    = a;
    operand_b_i    = b;
    operand_c_i    = $urandom();
    // Compares only steer the branch, nothing goes to the register file
    rf_we_i        = !is_cmp;
    rf_waddr_i     = waddr;
    br_active      = is_cmp;
    exp_branch     = branch_model(op, a, b);
    push_expected(!is_cmp, waddr, alu_model(op, a, b));
    wait_accept("ALU instruction");
    drive_idle();
    @(posedge clk);
    #2;
  endtask

  // stall holds wb_ready_i low for that many edges, kill_at kills after that many edges
  task automatic run_div(input div_op_e op, input word_t a, input word_t b,
                         input int stall, input int kill_at);
    rf_addr_t waddr;
    waddr          = rf_addr_t'($urandom());
    issued         = 1'b1;
    instr_valid_i  = 1'b1;
    alu_en_i       = 1'b0;
    div_en_i       = 1'b1;
    div_operator_i = op;
    operand_a_i    = a;
    operand_b_i    = b;
    operand_c_i    = $urandom();
    rf_we_i        = 1'b1;
    rf_waddr_i     = waddr;
    if (kill_at > 0) begin
      repeat (kill_at) @(posedge clk);
      #2;
      kill_i = 1'b1;
    end else begin
      push_expected(1'b1, waddr, div_model(op, a, b));
      if (stall > 0) begin
        wb_ready_i = 1'b0;
        repeat (stall) @(posedge clk);
        #2;
        wb_ready_i = 1'b1;
      end
    end
    wait_accept("division");
    drive_idle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_drained(input string name);
    int n;
    n = 0;
    while ((pending != 0) && (n < 4)) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("ERROR t=%0t %s left %0d result(s) that never reached WB", $time, name, pending);
      errors++;
      exp_q.delete();
      pending = 0;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s had %0d check failure(s)", name, errors - errors_before);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int    mark;
    word_t a;
    word_t b;

    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    pending      = 0;
    issued       = 1'b0;
    exp_we       = 1'b0;
    exp_waddr    = '0;
    exp_wdata    = '0;
    exp_branch   = 1'b0;
    void'($urandom(79105));

    rst_n          = 1'b0;
    halt_i         = 1'b0;
    wb_ready_i     = 1'b1;
    alu_operator_i = ALU_ADD;
    div_operator_i = DIV_DIV;
    operand_a_i    = '0;
    operand_b_i    = '0;
    operand_c_i    = '0;
    rf_waddr_i     = '0;
    drive_idle();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Quiet outputs before the first issue
    mark = errors;
    repeat (3) @(posedge clk);
    #2;
    report_test("reset", mark);

    // Each ALU operator once, then random mix
    mark = errors;
    for (int k = 0; k < 10; k++) begin
      run_alu(alu_op_e'(k), $urandom(), $urandom());
    end
    for (int k = 0; k < 30; k++) begin
      run_alu(alu_op_e'($urandom_range(9, 0)), $urandom(), $urandom());
    end
    check_drained("alu_ops");
    report_test("alu_ops", mark);

    // Equal, random, and a sign-sensitive pair per compare
    mark = errors;
    for (int k = 10; k < 16; k++) begin
      a = $urandom();
      run_alu(alu_op_e'(k), a, a);
      run_alu(alu_op_e'(k), a, $urandom());
      run_alu(alu_op_e'(k), 32'hffff_ffff, 32'h0000_0001);
    end
    check_drained("branch");
    report_test("branch", mark);

    // Divisor magnitudes spread over the whole range, either sign
    mark = errors;
    for (int k = 0; k < 24; k++) begin
      b = $urandom() >> $urandom_range(31, 0);
      if ($urandom_range(1, 0) == 1) begin
        b = -b;
      end
      run_div(div_op_e'(k % 4), $urandom(), b, 0, 0);
    end
    for (int k = 0; k < 4; k++) begin
      run_div(div_op_e'(k), $urandom(), '0, 0, 0);
    end
    run_div(DIV_DIV, 32'h8000_0000, 32'hffff_ffff, 0, 0);
    run_div(DIV_REM, 32'h8000_0000, 32'hffff_ffff, 0, 0);
    check_drained("division");
    report_test("division", mark);

    // Stall past the worst case, then a stall that ends mid-run
    mark = errors;
    run_div(DIV_DIVU, $urandom(), $urandom() >> 8, DIV_MAX_CYCLES + 5, 0);
    run_div(DIV_REM, $urandom(), 32'd7, 12, 0);
    run_alu(ALU_XOR, $urandom(), $urandom());
    check_drained("backpressure");
    report_test("backpressure", mark);

    // Small divisors keep the division busy until the kill
    mark = errors;
    run_div(DIV_DIV, $urandom(), ($urandom() & 32'hff) | 32'h1, 0, 5);
    run_alu(ALU_ADD, $urandom(), $urandom());
    run_div(DIV_REMU, $urandom(), ($urandom() & 32'hff) | 32'h1, 0, 1);
    run_alu(ALU_SRA, $urandom(), $urandom());
    check_drained("kill");
    report_test("kill", mark);

    $display("summary: %0d tests, %0d failed, %0d check failures",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
